// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  la32_pkg::alu_op_e op,
    input  logic [31:0]       src1,
    input  logic [31:0]       src2,
    output logic [31:0]       result
);
    import la32_pkg::*;

    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            alu_add: begin
                result = src1 + src2;
            end
            alu_sub: begin
                result = src1 - src2;
            end
            alu_slt: begin
                result = {31'b0, lt_signed};
            end
            alu_sltu: begin
                result = {31'b0, lt_unsigned};
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_nor: begin
                result = ~(src1 | src2);
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_sll: begin
                result = src1 << shamt;
            end
            alu_srl: begin
                result = src1 >> shamt;
            end
            alu_sra: begin
                result = $signed(src1) >>> shamt;
            end
            // Immediate is already shifted up.
            alu_lui: begin
                result = src2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: design/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetch_valid,
    input  la32_pkg::fetch_pkt_t fetch,
    output la32_pkg::redirect_t  redirect,
    output logic                 commit_valid,
    output la32_pkg::commit_t    commit
);
    import la32_pkg::*;

    reg_idx_t    rf_raddr1;
    reg_idx_t    rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        rf_we;
    reg_idx_t    rf_waddr;
    logic [31:0] rf_wdata;

    logic        ex_valid;
    ex_pkt_t     ex_pkt;
    logic        wb_valid;
    commit_t     wb_pkt;
    fwd_t        ex_fwd;
    fwd_t        wb_fwd;

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .ex_valid    (ex_valid),
        .ex_pkt      (ex_pkt),
        .redirect    (redirect),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .ex_fwd      (ex_fwd),
        .wb_fwd      (wb_fwd)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_pkt   (ex_pkt),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt),
        .ex_fwd   (ex_fwd)
    );

    result_stage u_result (
        .clk          (clk),
        .reset        (reset),
        .wb_valid     (wb_valid),
        .wb_pkt       (wb_pkt),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .wb_fwd       (wb_fwd),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetch_valid,
    input  la32_pkg::fetch_pkt_t fetch,
    output logic                 ex_valid,
    output la32_pkg::ex_pkt_t    ex_pkt,
    output la32_pkg::redirect_t  redirect,
    output la32_pkg::reg_idx_t   rf_raddr1,
    output la32_pkg::reg_idx_t   rf_raddr2,
    input  logic [31:0]          rf_rdata1,
    input  logic [31:0]          rf_rdata2,
    input  la32_pkg::fwd_t       ex_fwd,
    input  la32_pkg::fwd_t       wb_fwd
);
    import la32_pkg::*;

    logic        dec_valid;
    fetch_pkt_t  dec_pkt;
    logic [31:0] inst;
    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;

    logic [31:0] si12;
    logic [31:0] ui12;
    logic [31:0] ui5;
    logic [31:0] si20;
    logic [31:0] offs16;
    logic [31:0] offs26;

    logic        known;
    alu_op_e     alu_op;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        src2_is_rd;
    logic        gr_we;
    logic        dst_is_r1;
    logic [31:0] imm;
    logic        is_jump;
    logic        is_jirl;
    logic        is_beq;
    logic        is_bne;
    logic        use_offs26;

    reg_idx_t    dest_raw;
    logic        writes_reg;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic        br_taken;
    logic [31:0] br_target;

    // Newest result wins: execute, then writeback, then the register file.
    function automatic logic [31:0] operand(input reg_idx_t idx, input logic [31:0] rf_value,
                                            input fwd_t ex_f, input fwd_t wb_f);
        logic [31:0] value;
        value = rf_value;
        if (idx != '0 && wb_f.valid && wb_f.dest == idx) begin
            value = wb_f.value;
        end
        if (idx != '0 && ex_f.valid && ex_f.dest == idx) begin
            value = ex_f.value;
        end
        return value;
    endfunction

    // Wrong-path fetch is dropped while a redirect is out.
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid && !br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && !br_taken) begin
            dec_pkt <= fetch;
        end
    end

    assign inst = dec_pkt.inst;
    assign op6  = inst[31:26];
    assign op4  = inst[25:22];
    assign op2  = inst[21:20];
    assign op5  = inst[19:15];
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui12   = {20'b0, inst[21:10]};
    assign ui5    = {27'b0, inst[14:10]};
    assign si20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    always_comb begin
        known       = 1'b1;
        alu_op      = alu_add;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        src2_is_rd  = 1'b0;
        gr_we       = 1'b0;
        dst_is_r1   = 1'b0;
        imm         = si12;
        is_jump     = 1'b0;
        is_jirl     = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        use_offs26  = 1'b0;
        case (op6)
            op_alu: begin
                gr_we = 1'b1;
                if (op4 == 4'h0 && op2 == 2'h1) begin
                    // 3R format.
                    case (op5)
                        5'h00: alu_op = alu_add;
                        5'h02: alu_op = alu_sub;
                        5'h04: alu_op = alu_slt;
                        5'h05: alu_op = alu_sltu;
                        5'h08: alu_op = alu_nor;
                        5'h09: alu_op = alu_and;
                        5'h0a: alu_op = alu_or;
                        5'h0b: alu_op = alu_xor;
                        5'h0e: alu_op = alu_sll;
                        5'h0f: alu_op = alu_srl;
                        5'h10: alu_op = alu_sra;
                        default: known = 1'b0;
                    endcase
                end else if (op4 == 4'h1 && op2 == 2'h0) begin
                    src2_is_imm = 1'b1;
                    imm         = ui5;
                    case (op5)
                        5'h01: alu_op = alu_sll;
                        5'h09: alu_op = alu_srl;
                        5'h11: alu_op = alu_sra;
                        default: known = 1'b0;
                    endcase
                end else begin
                    src2_is_imm = 1'b1;
                    case (op4)
                        4'h8: alu_op = alu_slt;
                        4'h9: alu_op = alu_sltu;
                        4'ha: alu_op = alu_add;
                        4'hd: begin
                            alu_op = alu_and;
                            imm    = ui12;
                        end
                        4'he: begin
                            alu_op = alu_or;
                            imm    = ui12;
                        end
                        4'hf: begin
                            alu_op = alu_xor;
                            imm    = ui12;
                        end
                        default: known = 1'b0;
                    endcase
                end
            end
            op_lu12i, op_pcaddu12i: begin
                known       = !inst[25];
                alu_op      = (op6 == op_lu12i) ? alu_lui : alu_add;
                src1_is_pc  = (op6 == op_pcaddu12i);
                src2_is_imm = 1'b1;
                gr_we       = 1'b1;
                imm         = si20;
            end
            op_jirl, op_bl: begin
                // Link value is pc + 4.
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                gr_we       = 1'b1;
                imm         = link_offset;
                is_jump     = 1'b1;
                is_jirl     = (op6 == op_jirl);
                dst_is_r1   = (op6 == op_bl);
                use_offs26  = (op6 == op_bl);
            end
            op_b: begin
                is_jump    = 1'b1;
                use_offs26 = 1'b1;
            end
            op_beq, op_bne: begin
                src2_is_rd = 1'b1;
                is_beq     = (op6 == op_beq);
                is_bne     = (op6 == op_bne);
            end
            default: known = 1'b0;
        endcase
    end

    assign rf_raddr1 = rj;
    assign rf_raddr2 = src2_is_rd ? rd : rk;
    assign rj_value  = operand(rf_raddr1, rf_rdata1, ex_fwd, wb_fwd);
    assign rkd_value = operand(rf_raddr2, rf_rdata2, ex_fwd, wb_fwd);

    // r0 as a target means no write at all.
    assign dest_raw   = dst_is_r1 ? link_reg : rd;
    assign writes_reg = known && gr_we && dest_raw != '0;

    assign br_taken  = dec_valid && known && (is_jump ||
                       (is_beq && rj_value == rkd_value) ||
                       (is_bne && rj_value != rkd_value));
    assign br_target = is_jirl ? rj_value + offs16 :
                       dec_pkt.pc + (use_offs26 ? offs26 : offs16);

    assign redirect.taken  = br_taken;
    assign redirect.target = br_target;

    assign ex_valid           = dec_valid && known;
    assign ex_pkt.pc          = dec_pkt.pc;
    assign ex_pkt.rj_value    = rj_value;
    assign ex_pkt.rkd_value   = rkd_value;
    assign ex_pkt.imm         = imm;
    assign ex_pkt.alu_op      = alu_op;
    assign ex_pkt.src1_is_pc  = src1_is_pc;
    assign ex_pkt.src2_is_imm = src2_is_imm;
    assign ex_pkt.dest        = writes_reg ? dest_raw : '0;
    assign ex_pkt.gr_we       = writes_reg;

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  la32_pkg::ex_pkt_t   ex_pkt,
    output logic                wb_valid,
    output la32_pkg::commit_t   wb_pkt,
    output la32_pkg::fwd_t      ex_fwd
);
    import la32_pkg::*;

    logic        valid_r;
    ex_pkt_t     pkt_r;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        pkt_r <= ex_pkt;
    end

    assign src1 = pkt_r.src1_is_pc ? pkt_r.pc : pkt_r.rj_value;
    assign src2 = pkt_r.src2_is_imm ? pkt_r.imm : pkt_r.rkd_value;

    alu u_alu (
        .op     (pkt_r.alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    assign wb_valid     = valid_r;
    assign wb_pkt.pc    = pkt_r.pc;
    assign wb_pkt.we    = pkt_r.gr_we;
    assign wb_pkt.dest  = pkt_r.dest;
    assign wb_pkt.value = alu_result;

    // Same-cycle result back to decode.
    assign ex_fwd.valid = valid_r && pkt_r.gr_we;
    assign ex_fwd.dest  = pkt_r.dest;
    assign ex_fwd.value = alu_result;

endmodule

// File: design/la32_pkg.sv
package la32_pkg;

    localparam int xlen  = 32;
    localparam int nregs = 32;

    typedef logic [4:0] reg_idx_t;

    // bl writes its return address here.
    localparam reg_idx_t link_reg = 5'd1;
    localparam logic [xlen-1:0] link_offset = 32'd4;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // Major opcode, inst[31:26].
    typedef enum logic [5:0] {
        op_alu       = 6'h00,
        op_lu12i     = 6'h05,
        op_pcaddu12i = 6'h07,
        op_jirl      = 6'h13,
        op_b         = 6'h14,
        op_bl        = 6'h15,
        op_beq       = 6'h16,
        op_bne       = 6'h17
    } major_op_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        reg_idx_t        dest;
        logic            gr_we;
    } ex_pkt_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        dest;
        logic [xlen-1:0] value;
    } fwd_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            we;
        reg_idx_t        dest;
        logic [xlen-1:0] value;
    } commit_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  la32_pkg::reg_idx_t raddr1,
    output logic [31:0]        rdata1,
    input  la32_pkg::reg_idx_t raddr2,
    output logic [31:0]        rdata2,
    input  logic               we,
    input  la32_pkg::reg_idx_t waddr,
    input  logic [31:0]        wdata
);
    import la32_pkg::*;

    // r0 has no storage.
    logic [xlen-1:0] regs [1:nregs-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: design/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_valid,
    input  la32_pkg::commit_t  wb_pkt,
    output logic               rf_we,
    output la32_pkg::reg_idx_t rf_waddr,
    output logic [31:0]        rf_wdata,
    output la32_pkg::fwd_t     wb_fwd,
    output logic               commit_valid,
    output la32_pkg::commit_t  commit
);
    import la32_pkg::*;

    logic    valid_r;
    commit_t pkt_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        pkt_r <= wb_pkt;
    end

    assign rf_we    = valid_r && pkt_r.we;
    assign rf_waddr = pkt_r.dest;
    assign rf_wdata = pkt_r.value;

    // Covers decode reading the register being written this cycle.
    assign wb_fwd.valid = rf_we;
    assign wb_fwd.dest  = pkt_r.dest;
    assign wb_fwd.value = pkt_r.value;

    assign commit_valid = valid_r;
    assign commit       = pkt_r;

endmodule

// File: filelist.f
design/la32_pkg.sv
design/reg_file.sv
design/alu.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
testbench/core_assert.sv
testbench/core_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f filelist.f -o core_sim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

output=$(./obj_dir/core_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Testbench passed"; then
    exit 0
fi
exit 1

// File: testbench/core_assert.sv
`timescale 1ns/1ps

module core_assert (
    input logic                clk,
    input logic                reset,
    input logic                commit_valid,
    input la32_pkg::commit_t   commit,
    input la32_pkg::redirect_t redirect
);

    // r0 targets must be cleared in decode.
    a_commit_no_r0: assert property (
        @(posedge clk) disable iff (reset)
        commit_valid |-> !(commit.we && commit.dest == 5'd0)
    ) else $error("commit has we high with dest r0");

    // Quiet through reset and one cycle past it.
    a_reset_quiet: assert property (
        @(posedge clk)
        reset |=> (!commit_valid && !redirect.taken)
    ) else $error("control output active during or right after reset");

    a_target_aligned: assert property (
        @(posedge clk) disable iff (reset)
        redirect.taken |-> (redirect.target[1:0] == 2'b00)
    ) else $error("redirect target is not word aligned");

endmodule

bind core_top core_assert u_core_assert (
    .clk          (clk),
    .reset        (reset),
    .commit_valid (commit_valid),
    .commit       (commit),
    .redirect     (redirect)
);

// File: testbench/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import la32_pkg::*;

    localparam int nprog          = 41;
    localparam int reset_cycles   = 16;
    localparam int timeout_cycles = nprog * 4 + reset_cycles + 64;

    logic        clk;
    logic        reset;
    logic        fetch_valid;
    fetch_pkt_t  fetch;
    redirect_t   redirect;
    logic        commit_valid;
    commit_t     commit;

    logic [31:0] prog [0:nprog-1];
    commit_t     expected [$];
    logic [15:0] lfsr;
    logic [31:0] pc;
    int          cyc;
    int          accept_edge;
    logic        first_commit;
    int          mismatches;
    int          protocol_errors;

    core_top UUT (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .redirect     (redirect),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Galois LFSR, taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] enc_3r(input logic [4:0] op5, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_sh(input logic [4:0] op5, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] ui5);
        return {6'h00, 4'h1, 2'h0, op5, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [3:0] op4, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [11:0] imm);
        return {6'h00, op4, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_u20(input logic [5:0] op6, input logic [4:0] rd,
                                            input logic [19:0] imm);
        return {op6, 1'b0, imm, rd};
    endfunction

    // Offsets are in words.
    function automatic logic [31:0] enc_br(input logic [5:0] op6, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_b26(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    task automatic load_program();
        prog[0]  = enc_i12(4'ha, 1, 0, 12'h7ff);
        prog[1]  = enc_i12(4'ha, 2, 0, 12'hffb);
        // Distances 1 and 2, then 1 and 3.
        prog[2]  = enc_3r(5'h00, 3, 1, 2);
        prog[3]  = enc_3r(5'h02, 4, 3, 1);
        prog[4]  = enc_3r(5'h04, 5, 2, 1);
        prog[5]  = enc_3r(5'h05, 6, 2, 1);
        prog[6]  = enc_3r(5'h09, 7, 3, 2);
        prog[7]  = enc_3r(5'h0a, 8, 3, 2);
        prog[8]  = enc_3r(5'h0b, 9, 3, 2);
        prog[9]  = enc_3r(5'h08, 10, 3, 2);
        prog[10] = enc_sh(5'h01, 11, 1, 4);
        prog[11] = enc_3r(5'h0e, 12, 2, 11);
        prog[12] = enc_3r(5'h0f, 13, 2, 1);
        prog[13] = enc_3r(5'h10, 14, 2, 5);
        prog[14] = enc_sh(5'h09, 15, 2, 3);
        prog[15] = enc_sh(5'h11, 16, 2, 3);
        prog[16] = enc_i12(4'h8, 17, 2, 12'hffd);
        prog[17] = enc_i12(4'h9, 18, 2, 12'h005);
        prog[18] = enc_i12(4'hd, 19, 2, 12'h0f0);
        prog[19] = enc_i12(4'he, 20, 1, 12'h800);
        prog[20] = enc_i12(4'hf, 21, 2, 12'h0ff);
        prog[21] = enc_u20(6'h05, 22, 20'h12345);
        prog[22] = enc_u20(6'h07, 23, 20'h00001);
        prog[23] = enc_i12(4'ha, 0, 1, 12'h005);
        prog[24] = enc_3r(5'h00, 24, 0, 1);
        prog[25] = enc_br(6'h16, 1, 1, 16'd2);
        prog[26] = enc_i12(4'ha, 25, 0, 12'h001);
        prog[27] = enc_br(6'h17, 2, 1, 16'd2);
        prog[28] = enc_i12(4'ha, 25, 0, 12'h002);
        prog[29] = enc_br(6'h16, 2, 1, 16'd2);
        prog[30] = enc_br(6'h17, 1, 1, 16'd2);
        prog[31] = enc_b26(6'h14, 26'd2);
        prog[32] = enc_i12(4'ha, 25, 0, 12'h003);
        prog[33] = enc_b26(6'h15, 26'd2);
        prog[34] = enc_i12(4'ha, 25, 0, 12'h004);
        prog[35] = enc_i12(4'ha, 26, 0, 12'd152);
        prog[36] = enc_br(6'h13, 27, 26, 16'd0);
        prog[37] = enc_i12(4'ha, 25, 0, 12'h005);
        prog[38] = enc_3r(5'h00, 28, 27, 1);
        prog[39] = enc_i12(4'ha, 29, 28, 12'h001);
        prog[40] = enc_3r(5'h0a, 30, 29, 28);
    endtask

    // Sequential ISA model of the whole program.
    task automatic run_reference();
        logic [31:0] regs [0:31];
        logic [31:0] rpc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s12;
        logic [31:0] u12;
        logic [31:0] val;
        logic [31:0] nxt;
        logic [4:0]  rd;
        logic        we;
        commit_t     c;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        rpc = '0;
        steps = 0;
        while (rpc < nprog * 4 && steps < 1000) begin
            inst = prog[rpc[31:2]];
            rd   = inst[4:0];
            a    = regs[inst[9:5]];
            b    = regs[inst[14:10]];
            s12  = {{20{inst[21]}}, inst[21:10]};
            u12  = {20'b0, inst[21:10]};
            we   = 1'b1;
            val  = '0;
            nxt  = rpc + 4;
            case (inst[31:26])
                6'h00: begin
                    if (inst[25:20] == 6'b000001) begin
                        case (inst[19:15])
                            5'h00: val = a + b;
                            5'h02: val = a - b;
                            5'h04: val = {31'b0, $signed(a) < $signed(b)};
                            5'h05: val = {31'b0, a < b};
                            5'h08: val = ~(a | b);
                            5'h09: val = a & b;
                            5'h0a: val = a | b;
                            5'h0b: val = a ^ b;
                            5'h0e: val = a << b[4:0];
                            5'h0f: val = a >> b[4:0];
                            5'h10: val = $signed(a) >>> b[4:0];
                            default: we = 1'b0;
                        endcase
                    end else if (inst[25:20] == 6'b000100) begin
                        case (inst[19:15])
                            5'h01: val = a << inst[14:10];
                            5'h09: val = a >> inst[14:10];
                            5'h11: val = $signed(a) >>> inst[14:10];
                            default: we = 1'b0;
                        endcase
                    end else begin
                        case (inst[25:22])
                            4'h8: val = {31'b0, $signed(a) < $signed(s12)};
                            4'h9: val = {31'b0, a < s12};
                            4'ha: val = a + s12;
                            4'hd: val = a & u12;
                            4'he: val = a | u12;
                            4'hf: val = a ^ u12;
                            default: we = 1'b0;
                        endcase
                    end
                end
                6'h05: val = {inst[24:5], 12'b0};
                6'h07: val = rpc + {inst[24:5], 12'b0};
                6'h13: begin
                    val = rpc + 4;
                    nxt = a + {{14{inst[25]}}, inst[25:10], 2'b0};
                end
                6'h14: begin
                    we  = 1'b0;
                    nxt = rpc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
                end
                6'h15: begin
                    rd  = 5'd1;
                    val = rpc + 4;
                    nxt = rpc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
                end
                6'h16, 6'h17: begin
                    we = 1'b0;
                    if ((a == regs[rd]) == (inst[31:26] == 6'h16)) begin
                        nxt = rpc + {{14{inst[25]}}, inst[25:10], 2'b0};
                    end
                end
                default: we = 1'b0;
            endcase
            if (rd == 5'd0) begin
                we = 1'b0;
            end
            if (we) begin
                regs[rd] = val;
            end
            c.pc    = rpc;
            c.we    = we;
            c.dest  = we ? rd : 5'd0;
            c.value = val;
            expected.push_back(c);
            rpc = nxt;
            steps++;
        end
    endtask

    task automatic drive_fetch();
        logic bubble;
        bubble = lfsr[0];
        lfsr = lfsr_next(lfsr);
        fetch.pc   = pc;
        fetch.inst = (pc < nprog * 4) ? prog[pc[31:2]] : 32'h0;
        fetch_valid = !bubble && pc < nprog * 4;
    endtask

    task automatic check_commit();
        commit_t e;
        if (first_commit) begin
            first_commit = 1'b0;
            assert (cyc == accept_edge + 2) else begin
                $display("ERROR %0t: first commit after edge %0d, accepted at edge %0d",
                         $time, cyc, accept_edge);
                protocol_errors++;
            end
        end
        if (expected.size() == 0) begin
            $display("Unexpected commit at pc %h after the reference stream ended", commit.pc);
            protocol_errors++;
        end else begin
            e = expected.pop_front();
            assert (commit.pc == e.pc && commit.we == e.we && commit.dest == e.dest &&
                    (!e.we || commit.value == e.value)) else begin
                $display("ERROR %0t: commit pc %h we %b r%0d=%h, expected pc %h we %b r%0d=%h",
                         $time, commit.pc, commit.we, commit.dest, commit.value,
                         e.pc, e.we, e.dest, e.value);
                mismatches++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (accept_edge < 0) begin
                assert (!commit_valid && !redirect.taken) else begin
                    $display("ERROR %0t: output active before any instruction was accepted",
                             $time);
                    protocol_errors++;
                end
                if (fetch_valid) begin
                    accept_edge = cyc + 1;
                end
            end
            if (commit_valid) begin
                check_commit();
            end
        end
    end

    initial begin
        #(timeout_cycles * 8);
        $display("Timeout: commit stream incomplete after %0d cycles", timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch = '0;
        pc = '0;
        lfsr = 16'd68;
        cyc = 0;
        accept_edge = -1;
        first_commit = 1'b1;
        mismatches = 0;
        protocol_errors = 0;
        load_program();
        run_reference();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_fetch();
        while (expected.size() != 0) begin
            @(negedge clk);
            // Follow a redirect, else step past an accepted packet.
            if (redirect.taken) begin
                pc = redirect.target;
            end else if (fetch_valid) begin
                pc = pc + 4;
            end
            @(posedge clk);
            #1;
            drive_fetch();
        end
        fetch_valid = 1'b0;
        repeat (8) @(posedge clk);
        $display("Done: %0d commit mismatches, %0d protocol errors", mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
